/* src.f */
design/if_pkg.sv
design/fetch_if.sv
design/pc_select.sv
design/prefetch_unit.sv
design/if_id_register.sv
design/if_stage.sv
dv/if_stage_chk.sv
dv/if_stage_tb.sv

/* Makefile */
# Verilator simulation of the instruction fetch stage

VERILATOR ?= verilator
TOP       ?= if_stage_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
PASS_MSG  ?= Verification passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* dv/if_stage_tb.sv */
////////////////////////////////////////
// Fetch stage testbench with clock, bus
// memory model, scenario table and checks
////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module if_stage_tb import if_pkg::*; ();

        localparam addr_t DATA_KEY       = 32'hA5F0_3C96;
        localparam addr_t ERR_ADDR       = 32'h0000_1008;
        localparam int    NUM_SCEN       = 6;
        localparam int    MAX_WORDS      = 8;
        localparam int    TIMEOUT_CYCLES = NUM_SCEN * MAX_WORDS * 12;

        typedef struct packed {
                pc_mux_e     mux;
                exc_pc_mux_e mode;
                exc_cause_t  cause;
                addr_t       oper;
                trap_base_t  base;
                addr_t       first_pc;
                logic [3:0]  words;
                logic [7:0]  ready;
        } scenario_t;

        logic        clk;
        logic        reset_i;
        logic        req_i;
        logic        pc_set_i;
        pc_mux_e     pc_mux_i;
        exc_pc_mux_e exc_pc_mux_i;
        exc_cause_t  exc_cause_i;
        addr_t       boot_addr_i;
        addr_t       jump_target_i;
        addr_t       mepc_i;
        trap_base_t  m_trap_base_addr_i;
        logic        instr_req_o;
        addr_t       instr_addr_o;
        logic        instr_gnt_i;
        logic        instr_rvalid_i;
        instr_t      instr_rdata_i;
        logic        instr_err_i;
        logic        clear_instr_valid_i;
        logic        id_ready_i;
        logic        instr_valid_id_o;
        instr_t      instr_rdata_id_o;
        addr_t       pc_id_o;
        logic        is_fetch_failed_o;
        logic        if_busy_o;

        scenario_t scenarios[$];

        if_stage UUT (.*);

        initial begin
                clk = 1'b0;
                forever #20 clk = ~clk;
        end

        ////////////////////////////////////////
        // Helpers
        ////////////////////////////////////////

        task automatic stop_with_error(input string msg);
                $display("%s", msg);
                $display("Verification failed");
                $fatal(1);
        endtask

        task automatic check_value(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
                assert (actual === expected)
                else stop_with_error($sformatf("mismatch at time %0t: %s expected %h, actual %h",
                                               $time, name, expected, actual));
        endtask

        // Vector is base, one zero bit, cause in IRQ mode, two zero bits
        function automatic addr_t expected_first_pc(input pc_mux_e mux, input exc_pc_mux_e mode,
                                                    input exc_cause_t cause, input addr_t oper,
                                                    input trap_base_t base);
                exc_cause_t idx;
                idx = (mode == EXC_PC_IRQ) ? cause : 5'd0;
                if (mux == PC_EXCEPTION)
                        return {base, 1'b0, idx, 2'b00};
                return {oper[31:1], 1'b0};
        endfunction

        task automatic add_scenario(input pc_mux_e mux, input exc_pc_mux_e mode,
                                    input exc_cause_t cause, input addr_t oper,
                                    input trap_base_t base, input int words,
                                    input logic [7:0] ready);
                scenarios.push_back('{mux, mode, cause, oper, base,
                                      expected_first_pc(mux, mode, cause, oper, base),
                                      4'(words), ready});
        endtask

        ////////////////////////////////////////
        // Memory model
        ////////////////////////////////////////

        // One request in flight, grant and response delays of 0 to 2 cycles
        initial begin
                int    gnt_wait;
                int    rsp_wait;
                logic  pending;
                addr_t rsp_addr;
                void'($urandom(38));
                instr_gnt_i    = 1'b0;
                instr_rvalid_i = 1'b0;
                instr_rdata_i  = '0;
                instr_err_i    = 1'b0;
                pending        = 1'b0;
                gnt_wait       = 0;
                rsp_wait       = 0;
                rsp_addr       = '0;
                forever begin
                        @(negedge clk);
                        // A granted request is still waiting for its response
                        if (pending)
                                check_value("if_busy_o", 32'd1, 32'(if_busy_o));
                        instr_gnt_i    = 1'b0;
                        instr_rvalid_i = 1'b0;
                        instr_err_i    = 1'b0;
                        if (pending) begin
                                if (rsp_wait == 0) begin
                                        instr_rvalid_i = 1'b1;
                                        instr_rdata_i  = rsp_addr ^ DATA_KEY;
                                        instr_err_i    = (rsp_addr == ERR_ADDR);
                                        pending        = 1'b0;
                                        gnt_wait       = $urandom % 3;
                                end else begin
                                        rsp_wait--;
                                end
                        end else if (instr_req_o) begin
                                if (gnt_wait == 0) begin
                                        instr_gnt_i = 1'b1;
                                        pending     = 1'b1;
                                        rsp_addr    = instr_addr_o;
                                        rsp_wait    = $urandom % 3;
                                end else begin
                                        gnt_wait--;
                                end
                        end
                end
        end

        ////////////////////////////////////////
        // Scenario steps
        ////////////////////////////////////////

        task automatic run_scenario(input scenario_t sc);
                addr_t  exp_pc;
                addr_t  held_pc;
                instr_t held_data;
                logic   held;
                int     got;
                int     cyc;
                pc_mux_i           = sc.mux;
                exc_pc_mux_i       = sc.mode;
                exc_cause_i        = sc.cause;
                // Unselected sources carry decoys
                boot_addr_i        = (sc.mux == PC_BOOT) ? sc.oper : 32'h0000_7700;
                jump_target_i      = (sc.mux == PC_JUMP) ? sc.oper : 32'h0000_7800;
                mepc_i             = (sc.mux == PC_MRET) ? sc.oper : 32'h0000_7900;
                m_trap_base_addr_i = sc.base;
                pc_set_i           = 1'b1;
                @(negedge clk);
                pc_set_i  = 1'b0;
                exp_pc    = sc.first_pc;
                held      = 1'b0;
                held_pc   = '0;
                held_data = '0;
                got       = 0;
                cyc       = 0;
                while (got < int'(sc.words)) begin
                        id_ready_i = sc.ready[cyc % 8];
                        // Stalled word must still be there
                        if (held) begin
                                check_value("instr_valid_id_o", 32'd1, 32'(instr_valid_id_o));
                                check_value("pc_id_o", held_pc, pc_id_o);
                                check_value("instr_rdata_id_o", held_data, instr_rdata_id_o);
                        end
                        if (instr_valid_id_o && id_ready_i) begin
                                check_value("pc_id_o", exp_pc, pc_id_o);
                                check_value("instr_rdata_id_o", exp_pc ^ DATA_KEY,
                                            instr_rdata_id_o);
                                check_value("is_fetch_failed_o", 32'(exp_pc == ERR_ADDR),
                                            32'(is_fetch_failed_o));
                                exp_pc = exp_pc + addr_t'(INSTR_BYTES);
                                got++;
                        end
                        held      = instr_valid_id_o && !id_ready_i;
                        held_pc   = pc_id_o;
                        held_data = instr_rdata_id_o;
                        cyc++;
                        @(negedge clk);
                end
        endtask

        task automatic check_clear();
                id_ready_i = 1'b0;
                while (!instr_valid_id_o)
                        @(negedge clk);
                clear_instr_valid_i = 1'b1;
                @(negedge clk);
                clear_instr_valid_i = 1'b0;
                check_value("instr_valid_id_o", 32'd0, 32'(instr_valid_id_o));
        endtask

        initial begin
                int cycles;
                cycles = 0;
                forever begin
                        @(posedge clk);
                        cycles++;
                        if (cycles > TIMEOUT_CYCLES)
                                stop_with_error($sformatf("timeout: run not done after %0d cycles",
                                                          TIMEOUT_CYCLES));
                end
        end

        ////////////////////////////////////////
        // Main sequence
        ////////////////////////////////////////

        initial begin
                reset_i             = 1'b1;
                req_i               = 1'b0;
                pc_set_i            = 1'b0;
                pc_mux_i            = PC_BOOT;
                exc_pc_mux_i        = EXC_PC_EXCEPTION;
                exc_cause_i         = '0;
                boot_addr_i         = '0;
                jump_target_i       = '0;
                mepc_i              = '0;
                m_trap_base_addr_i  = '0;
                clear_instr_valid_i = 1'b0;
                id_ready_i          = 1'b0;

                add_scenario(PC_BOOT, EXC_PC_EXCEPTION, 5'd0, 32'h0000_0080, 24'h0, 4, 8'hFF);
                add_scenario(PC_JUMP, EXC_PC_EXCEPTION, 5'd0, 32'h0000_1000, 24'h0, 6, 8'hFF);
                add_scenario(PC_MRET, EXC_PC_EXCEPTION, 5'd0, 32'h0000_3A11, 24'h0, 8, 8'h0F);
                add_scenario(PC_EXCEPTION, EXC_PC_EXCEPTION, 5'd7, 32'h0, 24'h000040, 3, 8'hFF);
                add_scenario(PC_EXCEPTION, EXC_PC_IRQ, 5'd11, 32'h0, 24'h000050, 5, 8'hB3);
                add_scenario(PC_JUMP, EXC_PC_EXCEPTION, 5'd0, 32'h0000_0FF8, 24'h0, 5, 8'hFF);

                repeat (3) @(negedge clk);
                reset_i = 1'b0;
                req_i   = 1'b1;

                // Nothing is fetched before the first redirect
                repeat (4) begin
                        @(negedge clk);
                        check_value("instr_req_o", 32'd0, 32'(instr_req_o));
                        check_value("instr_valid_id_o", 32'd0, 32'(instr_valid_id_o));
                        check_value("if_busy_o", 32'd0, 32'(if_busy_o));
                end

                foreach (scenarios[i])
                        run_scenario(scenarios[i]);
                check_clear();

                // Bound assertions count their failures
                if (UUT.u_chk.fail_count == 0) begin
                        $display("Verification passed");
                        $finish;
                end else begin
                        stop_with_error("bound protocol assertions failed during the run");
                end
        end

endmodule

`default_nettype wire

/* dv/if_stage_chk.sv */
////////////////////////////////////////
// Concurrent assertions on the bus and
// the IF/ID register, bound to if_stage
////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module if_stage_chk import if_pkg::*; (
        input logic  clk,
        input logic  reset_i,
        input logic  pc_set_i,
        input logic  instr_req_o,
        input addr_t instr_addr_o,
        input logic  instr_gnt_i,
        input logic  instr_rvalid_i,
        input logic  instr_valid_id_o
);

        logic outstanding;
        // Failures seen, read by the testbench at the end
        int   fail_count = 0;

        // A granted request waits for its response
        always_ff @(posedge clk) begin
                if (reset_i) begin
                        outstanding <= 1'b0;
                end else if (instr_req_o && instr_gnt_i) begin
                        outstanding <= 1'b1;
                end else if (instr_rvalid_i) begin
                        outstanding <= 1'b0;
                end
        end

        ////////////////////////////////////////
        // Bus protocol
        ////////////////////////////////////////

        // Request and address hold until the grant
        addr_stable: assert property (@(posedge clk) disable iff (reset_i)
                instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
                else begin
                        $error("instr_req_o or instr_addr_o changed before the grant");
                        fail_count++;
                end

        rvalid_expected: assert property (@(posedge clk) disable iff (reset_i)
                instr_rvalid_i |-> outstanding)
                else begin
                        $error("instr_rvalid_i arrived with no outstanding request");
                        fail_count++;
                end

        ////////////////////////////////////////
        // IF/ID register
        ////////////////////////////////////////

        redirect_clears: assert property (@(posedge clk) disable iff (reset_i)
                pc_set_i |=> !instr_valid_id_o)
                else begin
                        $error("instr_valid_id_o still high after pc_set_i");
                        fail_count++;
                end

endmodule

bind if_stage if_stage_chk u_chk (.*);

`default_nettype wire

/* design/if_stage.sv */
////////////////////////////////////////
// Instruction fetch stage top level
////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module if_stage import if_pkg::*; (
        input  logic        clk,
        input  logic        reset_i,
        input  logic        req_i,
        input  logic        pc_set_i,
        input  pc_mux_e     pc_mux_i,
        input  exc_pc_mux_e exc_pc_mux_i,
        input  exc_cause_t  exc_cause_i,
        input  addr_t       boot_addr_i,
        input  addr_t       jump_target_i,
        input  addr_t       mepc_i,
        input  trap_base_t  m_trap_base_addr_i,
        output logic        instr_req_o,
        output addr_t       instr_addr_o,
        input  logic        instr_gnt_i,
        input  logic        instr_rvalid_i,
        input  instr_t      instr_rdata_i,
        input  logic        instr_err_i,
        input  logic        clear_instr_valid_i,
        input  logic        id_ready_i,
        output logic        instr_valid_id_o,
        output instr_t      instr_rdata_id_o,
        output addr_t       pc_id_o,
        output logic        is_fetch_failed_o,
        output logic        if_busy_o
);

        logic  branch;
        addr_t branch_addr;

        fetch_if fetch_bus ();

        pc_select u_pc_select (
                .clk                (clk),
                .reset_i            (reset_i),
                .pc_set_i           (pc_set_i),
                .pc_mux_i           (pc_mux_i),
                .exc_pc_mux_i       (exc_pc_mux_i),
                .exc_cause_i        (exc_cause_i),
                .boot_addr_i        (boot_addr_i),
                .jump_target_i      (jump_target_i),
                .mepc_i             (mepc_i),
                .m_trap_base_addr_i (m_trap_base_addr_i),
                .branch_o           (branch),
                .branch_addr_o      (branch_addr)
        );

        prefetch_unit u_prefetch_unit (
                .clk            (clk),
                .reset_i        (reset_i),
                .req_i          (req_i),
                .branch_i       (branch),
                .branch_addr_i  (branch_addr),
                .instr_req_o    (instr_req_o),
                .instr_addr_o   (instr_addr_o),
                .instr_gnt_i    (instr_gnt_i),
                .instr_rvalid_i (instr_rvalid_i),
                .instr_rdata_i  (instr_rdata_i),
                .instr_err_i    (instr_err_i),
                .busy_o         (if_busy_o),
                .fetch          (fetch_bus.src)
        );

        if_id_register u_if_id_register (
                .clk                 (clk),
                .reset_i             (reset_i),
                .pc_set_i            (pc_set_i),
                .clear_instr_valid_i (clear_instr_valid_i),
                .id_ready_i          (id_ready_i),
                .fetch               (fetch_bus.dst),
                .instr_valid_id_o    (instr_valid_id_o),
                .instr_rdata_id_o    (instr_rdata_id_o),
                .pc_id_o             (pc_id_o),
                .is_fetch_failed_o   (is_fetch_failed_o)
        );

endmodule

`default_nettype wire

/* design/if_id_register.sv */
////////////////////////////////////////
// IF/ID pipeline register
////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module if_id_register import if_pkg::*; (
        input  logic   clk,
        input  logic   reset_i,
        input  logic   pc_set_i,
        input  logic   clear_instr_valid_i,
        input  logic   id_ready_i,
        fetch_if.dst   fetch,
        output logic   instr_valid_id_o,
        output instr_t instr_rdata_id_o,
        output addr_t  pc_id_o,
        output logic   is_fetch_failed_o
);

        logic load;

        // Accept when decode takes the current word or the slot is free
        assign fetch.fetch_ready = (id_ready_i || !instr_valid_id_o) &&
                                   !pc_set_i && !clear_instr_valid_i;
        assign load = fetch.fetch_valid && fetch.fetch_ready;

        always_ff @(posedge clk) begin
                if (reset_i) begin
                        instr_valid_id_o <= 1'b0;
                end else if (pc_set_i || clear_instr_valid_i) begin
                        instr_valid_id_o <= 1'b0;
                end else if (load) begin
                        instr_valid_id_o <= 1'b1;
                end else if (id_ready_i) begin
                        // Word consumed with nothing behind it
                        instr_valid_id_o <= 1'b0;
                end
        end

        always_ff @(posedge clk) begin
                if (load) begin
                        instr_rdata_id_o  <= fetch.fetch_rdata;
                        pc_id_o           <= fetch.fetch_addr;
                        is_fetch_failed_o <= fetch.fetch_err;
                end
        end

endmodule

`default_nettype wire

/* design/prefetch_unit.sv */
////////////////////////////////////////
// Prefetch unit with bus request FSM,
// stale response discard and word buffer
////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module prefetch_unit import if_pkg::*; (
        input  logic   clk,
        input  logic   reset_i,
        input  logic   req_i,
        input  logic   branch_i,
        input  addr_t  branch_addr_i,
        output logic   instr_req_o,
        output addr_t  instr_addr_o,
        input  logic   instr_gnt_i,
        input  logic   instr_rvalid_i,
        input  instr_t instr_rdata_i,
        input  logic   instr_err_i,
        output logic   busy_o,
        fetch_if.src   fetch
);

        typedef enum logic [1:0] {IDLE, WAIT_GNT, WAIT_RVALID} pf_state_e;

        pf_state_e state_q;
        pf_state_e state_d;
        addr_t     next_addr_q;
        addr_t     req_addr_q;
        addr_t     rsp_addr_q;
        logic      fetch_en_q;
        logic      discard_q;
        logic      issue;
        logic      grant;
        logic      push;
        logic      pop;

        instr_t buf_rdata [FETCH_DEPTH];
        addr_t  buf_addr  [FETCH_DEPTH];
        logic   buf_err   [FETCH_DEPTH];

        logic [$clog2(FETCH_DEPTH)-1:0]   wr_ptr_q;
        logic [$clog2(FETCH_DEPTH)-1:0]   rd_ptr_q;
        logic [$clog2(FETCH_DEPTH+1)-1:0] count_q;

        ////////////////////////////////////////
        // Bus request side
        ////////////////////////////////////////

        // New request only with room for its response
        assign issue = (state_q == IDLE) && req_i && fetch_en_q && !branch_i &&
                       (count_q < FETCH_DEPTH);

        assign instr_req_o  = issue || (state_q == WAIT_GNT);
        // Held address while the grant is pending
        assign instr_addr_o = (state_q == WAIT_GNT) ? req_addr_q : next_addr_q;
        assign grant        = instr_req_o && instr_gnt_i;

        always_comb begin
                state_d = state_q;
                unique case (state_q)
                        IDLE:        if (issue) state_d = instr_gnt_i ? WAIT_RVALID : WAIT_GNT;
                        WAIT_GNT:    if (instr_gnt_i) state_d = WAIT_RVALID;
                        WAIT_RVALID: if (instr_rvalid_i) state_d = IDLE;
                        default:     state_d = IDLE;
                endcase
        end

        ////////////////////////////////////////
        // Buffer side
        ////////////////////////////////////////

        // Responses racing a branch are dropped
        assign push = (state_q == WAIT_RVALID) && instr_rvalid_i && !discard_q && !branch_i;
        assign pop  = fetch.fetch_valid && fetch.fetch_ready;

        assign fetch.fetch_valid = (count_q != '0) && !branch_i;
        assign fetch.fetch_rdata = buf_rdata[rd_ptr_q];
        assign fetch.fetch_addr  = buf_addr[rd_ptr_q];
        assign fetch.fetch_err   = buf_err[rd_ptr_q];

        assign busy_o = (state_q != IDLE) || (count_q != '0);

        always_ff @(posedge clk) begin
                if (reset_i) begin
                        state_q    <= IDLE;
                        fetch_en_q <= 1'b0;
                        discard_q  <= 1'b0;
                        count_q    <= '0;
                        wr_ptr_q   <= '0;
                        rd_ptr_q   <= '0;
                end else begin
                        state_q <= state_d;
                        if (branch_i) begin
                                fetch_en_q <= 1'b1;
                                // Outstanding response belongs to the old path
                                discard_q  <= (state_q == WAIT_GNT) ||
                                              (state_q == WAIT_RVALID && !instr_rvalid_i);
                                count_q    <= '0;
                                wr_ptr_q   <= '0;
                                rd_ptr_q   <= '0;
                        end else begin
                                if (state_q == WAIT_RVALID && instr_rvalid_i)
                                        discard_q <= 1'b0;
                                if (push)
                                        wr_ptr_q <= wr_ptr_q + 1'b1;
                                if (pop)
                                        rd_ptr_q <= rd_ptr_q + 1'b1;
                                case ({push, pop})
                                        2'b10:   count_q <= count_q + 1'b1;
                                        2'b01:   count_q <= count_q - 1'b1;
                                        default: count_q <= count_q;
                                endcase
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (state_q == IDLE)
                        req_addr_q <= next_addr_q;
                if (grant)
                        rsp_addr_q <= instr_addr_o;
                if (branch_i)
                        next_addr_q <= branch_addr_i;
                else if (grant && !discard_q)
                        next_addr_q <= instr_addr_o + addr_t'(INSTR_BYTES);
                if (push) begin
                        buf_rdata[wr_ptr_q] <= instr_rdata_i;
                        buf_addr[wr_ptr_q]  <= rsp_addr_q;
                        buf_err[wr_ptr_q]   <= instr_err_i;
                end
        end

endmodule

`default_nettype wire

/* design/pc_select.sv */
////////////////////////////////////////
// Redirect target selection and the
// registered branch request
////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module pc_select import if_pkg::*; (
        input  logic        clk,
        input  logic        reset_i,
        input  logic        pc_set_i,
        input  pc_mux_e     pc_mux_i,
        input  exc_pc_mux_e exc_pc_mux_i,
        input  exc_cause_t  exc_cause_i,
        input  addr_t       boot_addr_i,
        input  addr_t       jump_target_i,
        input  addr_t       mepc_i,
        input  trap_base_t  m_trap_base_addr_i,
        output logic        branch_o,
        output addr_t       branch_addr_o
);

        exc_cause_t vec_idx;
        addr_t      exc_pc;
        addr_t      target;

        ////////////////////////////////////////
        // Target selection
        ////////////////////////////////////////

        always_comb begin
                // Plain exceptions all enter at the base
                vec_idx = (exc_pc_mux_i == EXC_PC_IRQ) ? exc_cause_i : '0;
                exc_pc  = {m_trap_base_addr_i, 8'h00} | (addr_t'(vec_idx) << VEC_SHIFT);

                unique case (pc_mux_i)
                        PC_BOOT:      target = boot_addr_i;
                        PC_JUMP:      target = jump_target_i;
                        PC_MRET:      target = mepc_i;
                        PC_EXCEPTION: target = exc_pc;
                endcase
        end

        ////////////////////////////////////////
        // Branch request register
        ////////////////////////////////////////

        always_ff @(posedge clk) begin
                if (reset_i) begin
                        branch_o <= 1'b0;
                end else begin
                        branch_o <= pc_set_i;
                end
        end

        // Halfword bit is never set on a fetch address
        always_ff @(posedge clk) begin
                if (pc_set_i) begin
                        branch_addr_o <= {target[31:1], 1'b0};
                end
        end

endmodule

`default_nettype wire

/* design/fetch_if.sv */
////////////////////////////////////////
// Fetched word channel from the
// prefetch unit to the IF/ID register
////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

interface fetch_if import if_pkg::*; ();

        logic   fetch_valid;
        logic   fetch_ready;
        instr_t fetch_rdata;
        addr_t  fetch_addr;
        logic   fetch_err;

        // Prefetch side
        modport src (output fetch_valid, fetch_rdata, fetch_addr, fetch_err,
                      input  fetch_ready);

        // Pipeline register side
        modport dst (input  fetch_valid, fetch_rdata, fetch_addr, fetch_err,
                      output fetch_ready);

endinterface

`default_nettype wire

/* design/if_pkg.sv */
////////////////////////////////////////
// Shared types, enums and constants of
// the instruction fetch stage
////////////////////////////////////////
`default_nettype none

package if_pkg;

        // Byte address for PC and bus
        typedef logic [31:0] addr_t;

        // Whole aligned instruction word
        typedef logic [31:0] instr_t;

        // Upper bits of the machine trap vector base
        typedef logic [23:0] trap_base_t;

        // Interrupt cause, doubles as vector index
        typedef logic [4:0] exc_cause_t;

        // Redirect source
        typedef enum logic [1:0] {
                PC_BOOT      = 2'd0,
                PC_JUMP      = 2'd1,
                PC_MRET      = 2'd2,
                PC_EXCEPTION = 2'd3
        } pc_mux_e;

        // Trap vector mode
        typedef enum logic [0:0] {
                EXC_PC_EXCEPTION = 1'b0,
                EXC_PC_IRQ       = 1'b1
        } exc_pc_mux_e;

        localparam int INSTR_BYTES = 4;
        localparam int FETCH_DEPTH = 2;
        localparam int VEC_SHIFT   = 2;

endpackage

`default_nettype wire
